//--- compile.f
source/mips_pkg.sv
source/decode.sv
source/regfile.sv
source/operand_fetch.sv
source/id_stage.sv
test/tb_clock.sv
test/id_stage_tb.sv

//--- Makefile
# Verilator build for the ID stage testbench

TOP = id_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f compile.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\*\* PASSED \*\*\*'

clean:
	rm -rf obj_dir

//--- test/id_stage_tb.sv
module id_stage_tb;
    import mips_pkg::*;

    typedef struct packed {
        logic       legal;
        word_t      inst;
        id_bundle_t b;
    } exp_item_t;

    logic       clk;
    logic       rst_n;
    word_t      inst;
    logic       inst_valid;
    wb_t        wb;
    id_bundle_t out;
    logic       out_valid;

    logic [31:0] lfsr_state = 32'h3bea_1ba4;
    word_t       shadow [NUM_REGS];
    exp_item_t   exp_q [$];
    logic        prev_valid;
    int          mismatch_count;
    int          other_count;

    // legal encodings double as the model's decode table
    logic [31:0] enc_val [$];
    logic [31:0] enc_mask [$];
    oper_t       enc_oper [$];
    func_t       enc_func [$];

    tb_clock tb_clock_i (.clk(clk));

    id_stage id_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .wb         (wb),
        .out        (out),
        .out_valid  (out_valid)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic table_push(input logic [31:0] v, input logic [31:0] m,
                              input oper_t o, input func_t f);
        enc_val.push_back(v);
        enc_mask.push_back(m);
        enc_oper.push_back(o);
        enc_func.push_back(f);
    endtask

    task automatic special_fn(input logic [5:0] fn, input oper_t o, input func_t f);
        table_push({26'h0, fn}, 32'hfc00_003f, o, f);
    endtask

    task automatic main_op(input logic [5:0] op, input oper_t o, input func_t f);
        table_push({op, 26'h0}, 32'hfc00_0000, o, f);
    endtask

    task automatic regimm_rt(input logic [4:0] rt, input oper_t o);
        table_push({6'h01, 5'h0, rt, 16'h0}, 32'hfc1f_0000, o, func_and);
    endtask

    task automatic cop0_rs(input logic [4:0] rs, input oper_t o);
        table_push({6'h10, rs, 21'h0}, 32'hffe0_0000, o, func_and);
    endtask

    task automatic build_table();
        special_fn(6'h24, oper_alus, func_and);
        special_fn(6'h25, oper_alus, func_or);
        special_fn(6'h26, oper_alus, func_xor);
        special_fn(6'h27, oper_alus, func_nor);
        special_fn(6'h00, oper_alus, func_sll);
        special_fn(6'h02, oper_alus, func_srl);
        special_fn(6'h03, oper_alus, func_sra);
        special_fn(6'h04, oper_alus, func_sll);
        special_fn(6'h06, oper_alus, func_srl);
        special_fn(6'h07, oper_alus, func_sra);
        special_fn(6'h10, oper_mfhi, func_and);
        special_fn(6'h12, oper_mflo, func_and);
        special_fn(6'h11, oper_mthi, func_and);
        special_fn(6'h13, oper_mtlo, func_and);
        special_fn(6'h20, oper_alus, func_add);
        special_fn(6'h22, oper_alus, func_sub);
        special_fn(6'h2a, oper_alus, func_slt);
        special_fn(6'h18, oper_alus, func_mul);
        special_fn(6'h1a, oper_alus, func_div);
        special_fn(6'h21, oper_aluu, func_add);
        special_fn(6'h23, oper_aluu, func_sub);
        special_fn(6'h2b, oper_aluu, func_slt);
        special_fn(6'h19, oper_aluu, func_mul);
        special_fn(6'h1b, oper_aluu, func_div);
        special_fn(6'h08, oper_jr, func_and);
        special_fn(6'h09, oper_jr, func_and);         // jalr
        special_fn(6'h0d, oper_break, func_and);
        special_fn(6'h0c, oper_syscall, func_and);
        main_op(6'h0c, oper_aluu, func_and);
        main_op(6'h0d, oper_aluu, func_or);
        main_op(6'h0e, oper_aluu, func_xor);
        main_op(6'h0f, oper_aluu, func_lui);
        main_op(6'h08, oper_alus, func_add);
        main_op(6'h09, oper_aluu, func_add);
        main_op(6'h0a, oper_alus, func_slt);
        main_op(6'h0b, oper_aluu, func_slt);
        main_op(6'h02, oper_j, func_and);
        main_op(6'h03, oper_j, func_and);             // jal
        main_op(6'h04, oper_beq, func_and);
        main_op(6'h05, oper_bne, func_and);
        main_op(6'h07, oper_bgtz, func_and);
        main_op(6'h06, oper_blez, func_and);
        main_op(6'h20, oper_lb, func_add);
        main_op(6'h24, oper_lbu, func_add);
        main_op(6'h21, oper_lh, func_add);
        main_op(6'h25, oper_lhu, func_add);
        main_op(6'h23, oper_lw, func_add);
        main_op(6'h28, oper_sb, func_add);
        main_op(6'h29, oper_sh, func_add);
        main_op(6'h2b, oper_sw, func_add);
        regimm_rt(5'h00, oper_bltz);
        regimm_rt(5'h10, oper_bltz);                  // bltzal
        regimm_rt(5'h01, oper_bgez);
        regimm_rt(5'h11, oper_bgez);                  // bgezal
        cop0_rs(5'h04, oper_mtc0);
        cop0_rs(5'h00, oper_mfc0);
        cop0_rs(5'h10, oper_eret);
    endtask

    function automatic decoded_t model_decode(input word_t w);
        decoded_t d;
        int       k;
        logic     shamt_sh;
        logic     shift;
        logic     store;
        logic     jb;
        k = -1;
        d = '0;
        d.oper = oper_none;
        d.func = func_and;
        d.ri = 1'b1;
        for (int i = 0; i < enc_val.size(); i++) begin
            if ((w & enc_mask[i]) == enc_val[i])
                k = i;
        end
        if (k < 0)
            return d;
        d.ri = 1'b0;
        d.oper = enc_oper[k];
        d.func = enc_func[k];
        shift = d.func inside {func_sll, func_srl, func_sra};
        shamt_sh = (w[31:26] == 6'h00) && (w[5:0] inside {6'h00, 6'h02, 6'h03});
        store = d.oper inside {oper_sb, oper_sh, oper_sw};
        jb = d.oper inside {oper_jr, oper_j, oper_beq, oper_bne,
                            oper_bgtz, oper_blez, oper_bltz, oper_bgez};
        if (d.oper inside {oper_j, oper_break, oper_syscall, oper_eret})
            d.ityp = ityp_j;
        else if (shamt_sh || (w[31:26] != 6'h00 && w[31:26] != 6'h10))
            d.ityp = ityp_i;
        else
            d.ityp = ityp_r;
        if (d.ityp == ityp_j)
            d.imme = {6'h0, w[25:0]};
        else if (d.ityp == ityp_r)
            d.imme = '0;
        else if (shamt_sh)
            d.imme = {27'h0, w[10:6]};
        else if (d.oper == oper_aluu && d.func inside {func_and, func_or, func_xor, func_lui})
            d.imme = {16'h0, w[15:0]};      // logical immediates
        else
            d.imme = {{16{w[15]}}, w[15:0]};
        if (d.ityp == ityp_j || d.oper inside {oper_mtc0, oper_mfc0})
            d.rs = '0;
        else
            d.rs = shamt_sh ? w[20:16] : w[25:21];
        if (d.oper inside {oper_beq, oper_bne} || shift || store)
            d.rt = w[20:16];
        else if (d.oper == oper_mfc0)
            d.rt = w[15:11];
        else if (d.ityp != ityp_r)
            d.rt = '0;
        else
            d.rt = w[20:16];
        if (d.oper == oper_jr && w[5:0] == 6'h09)
            d.rd = (w[15:11] == 5'd0) ? LINK_REG : w[15:11];
        else if (w[31:26] == 6'h03 || (w[31:26] == 6'h01 && w[20]))
            d.rd = LINK_REG;
        else if (jb || store || d.ityp == ityp_j)
            d.rd = '0;
        else if (shift)
            d.rd = w[15:11];
        else if (d.ityp == ityp_i || d.oper == oper_mfc0)
            d.rd = w[20:16];
        else
            d.rd = w[15:11];
        d.sy = d.oper == oper_syscall;
        d.bp = d.oper == oper_break;
        d.er = d.oper == oper_eret;
        return d;
    endfunction

    function automatic word_t read_fwd(input reg_idx_t idx, input wb_t b);
        if (b.we && b.addr != 5'd0 && b.addr == idx)
            return b.data;
        return shadow[idx];
    endfunction

    function automatic exp_item_t model_item(input word_t w, input wb_t b);
        exp_item_t e;
        logic      imm_b;
        e.inst = w;
        e.b.dec = model_decode(w);
        e.legal = ~e.b.dec.ri;
        imm_b = (e.b.dec.ityp == ityp_i) &&
                !(e.b.dec.oper inside {oper_sb, oper_sh, oper_sw, oper_beq, oper_bne});
        e.b.op_a = read_fwd(e.b.dec.rs, b);
        e.b.op_b = imm_b ? e.b.dec.imme : read_fwd(e.b.dec.rt, b);
        return e;
    endfunction

    task automatic check_decoded(input string name, input decoded_t exp, input decoded_t act);
        if (exp !== act) begin
            mismatch_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            mismatch_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            mismatch_count++;
            $display("mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    // checks the last result and drives the next inputs at a falling edge
    task automatic cycle(input logic v, input word_t w, input wb_t b);
        exp_item_t e;
        check_valid("out_valid", prev_valid, out_valid);
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("out_valid high with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                if (e.legal) begin
                    check_decoded($sformatf("decode %h", e.inst), e.b.dec, out.dec);
                    check_word($sformatf("op_a %h", e.inst), e.b.op_a, out.op_a);
                    check_word($sformatf("op_b %h", e.inst), e.b.op_b, out.op_b);
                end else begin
                    check_valid($sformatf("ri %h", e.inst), 1'b1, out.dec.ri);
                    check_valid($sformatf("sy %h", e.inst), 1'b0, out.dec.sy);
                    check_valid($sformatf("bp %h", e.inst), 1'b0, out.dec.bp);
                    check_valid($sformatf("er %h", e.inst), 1'b0, out.dec.er);
                end
            end
        end
        inst = w;
        inst_valid = v;
        wb = b;
        if (v)
            exp_q.push_back(model_item(w, b));
        if (b.we && b.addr != 5'd0)
            shadow[b.addr] = b.data;
        prev_valid = v;
        @(negedge clk);
    endtask

    initial begin
        logic [31:0] r;
        word_t       w;
        wb_t         b;
        logic        v;
        int          idx;
        reg_idx_t    a;
        int          t;
        rst_n = 1'b0;
        inst = '0;
        inst_valid = 1'b0;
        wb = '0;
        prev_valid = 1'b0;
        mismatch_count = 0;
        other_count = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle after reset and then addu reads of every register
        repeat (4) cycle(1'b0, '0, '0);
        for (int i = 0; i < NUM_REGS; i++) begin
            a = i[4:0];
            cycle(1'b1, {6'h00, a, 5'd31 - a, 5'd1, 5'd0, 6'h21}, '0);
        end

        for (int n = 0; n < 3000; n++) begin
            v = rand_bits(2) != 0;
            if (rand_bits(3) != 0) begin
                idx = int'(rand_bits(6)) % enc_val.size();
                w = (rand_bits(32) & ~enc_mask[idx]) | enc_val[idx];
            end else begin
                w = rand_bits(32);
            end
            r = rand_bits(1);
            b.we = r[0];
            r = rand_bits(5);
            b.addr = r[4:0];
            b.data = rand_bits(32);
            cycle(v, w, b);
        end

        t = 0;
        cycle(1'b0, '0, '0);
        while (exp_q.size() != 0 && t < 10) begin
            cycle(1'b0, '0, '0);
            t++;
        end
        if (exp_q.size() != 0) begin
            other_count++;
            $display("timeout waiting for %0d outstanding results", exp_q.size());
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- test/tb_clock.sv
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;   // period 4

endmodule

//--- source/id_stage.sv
module id_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::word_t      inst,
    input  logic                 inst_valid,
    input  mips_pkg::wb_t        wb,
    output mips_pkg::id_bundle_t out,
    output logic                 out_valid
);
    import mips_pkg::*;

    decoded_t dec;
    word_t    rs_data;
    word_t    rt_data;

    decode decode_i (
        .inst (inst),
        .dec  (dec)
    );

    regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (dec.rs),
        .rt      (dec.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    operand_fetch operand_fetch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (inst_valid),
        .dec       (dec),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .wb        (wb),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

//--- source/operand_fetch.sv
module operand_fetch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dec_valid,
    input  mips_pkg::decoded_t   dec,
    input  mips_pkg::word_t      rs_data,
    input  mips_pkg::word_t      rt_data,
    input  mips_pkg::wb_t        wb,
    output mips_pkg::id_bundle_t out,
    output logic                 out_valid
);
    import mips_pkg::*;

    logic       wb_live;
    logic       fwd_rs;
    logic       fwd_rt;
    word_t      rs_val;
    word_t      rt_val;
    logic       two_reg_op;
    logic       use_imme;
    id_bundle_t nxt;

    // same-cycle write-back bypass
    assign wb_live = wb.we && (wb.addr != '0);
    assign fwd_rs  = wb_live && (wb.addr == dec.rs);
    assign fwd_rt  = wb_live && (wb.addr == dec.rt);
    assign rs_val  = fwd_rs ? wb.data : rs_data;
    assign rt_val  = fwd_rt ? wb.data : rt_data;

    // stores and beq/bne need rt as op_b
    assign two_reg_op = dec.oper inside {oper_sb, oper_sh, oper_sw, oper_beq, oper_bne};
    assign use_imme   = (dec.ityp == ityp_i) && !two_reg_op;

    always_comb begin
        nxt.dec  = dec;
        nxt.op_a = rs_val;                        // shamt shifts already carry rt here
        nxt.op_b = use_imme ? dec.imme : rt_val;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            out <= nxt;
        end
    end

endmodule

//--- source/regfile.sv
module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::reg_idx_t rs,
    input  mips_pkg::reg_idx_t rt,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    input  mips_pkg::wb_t      wb
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = wb.we && (wb.addr != '0);   // r0 stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // raw read with forwarding done downstream
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

endmodule

//--- source/decode.sv
module decode (
    input  mips_pkg::word_t    inst,
    output mips_pkg::decoded_t dec
);
    import mips_pkg::*;

    typedef struct packed {
        oper_t oper;
        func_t func;
    } op_fn_t;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   f_rs;
    reg_idx_t   f_rt;
    reg_idx_t   f_rd;
    op_fn_t     sel;
    logic       hit;
    ityp_t      ityp;
    word_t      imme;
    logic       is_shift;
    logic       imm_shift;
    logic       is_store;
    logic       is_jb;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd_base;
    reg_idx_t   rd;
    logic       link_jalr;
    logic       link_jal;
    logic       link_bal;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign f_rs   = inst[25:21];
    assign f_rt   = inst[20:16];
    assign f_rd   = inst[15:11];

    always_comb begin
        hit = 1'b1;
        sel = '{oper_none, func_and};
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    6'b100100: sel = '{oper_alus, func_and};      // and
                    6'b100101: sel = '{oper_alus, func_or};       // or
                    6'b100110: sel = '{oper_alus, func_xor};      // xor
                    6'b100111: sel = '{oper_alus, func_nor};      // nor
                    6'b000000: sel = '{oper_alus, func_sll};      // sll
                    6'b000010: sel = '{oper_alus, func_srl};      // srl
                    6'b000011: sel = '{oper_alus, func_sra};      // sra
                    6'b000100: sel = '{oper_alus, func_sll};      // sllv
                    6'b000110: sel = '{oper_alus, func_srl};      // srlv
                    6'b000111: sel = '{oper_alus, func_sra};      // srav
                    6'b010000: sel = '{oper_mfhi, func_and};
                    6'b010010: sel = '{oper_mflo, func_and};
                    6'b010001: sel = '{oper_mthi, func_and};
                    6'b010011: sel = '{oper_mtlo, func_and};
                    6'b100000: sel = '{oper_alus, func_add};      // add
                    6'b100010: sel = '{oper_alus, func_sub};      // sub
                    6'b101010: sel = '{oper_alus, func_slt};      // slt
                    6'b011000: sel = '{oper_alus, func_mul};      // mult
                    6'b011010: sel = '{oper_alus, func_div};      // div
                    6'b100001: sel = '{oper_aluu, func_add};      // addu
                    6'b100011: sel = '{oper_aluu, func_sub};      // subu
                    6'b101011: sel = '{oper_aluu, func_slt};      // sltu
                    6'b011001: sel = '{oper_aluu, func_mul};      // multu
                    6'b011011: sel = '{oper_aluu, func_div};      // divu
                    6'b001000: sel = '{oper_jr, func_and};        // jr
                    FN_JALR:   sel = '{oper_jr, func_and};        // jalr
                    6'b001101: sel = '{oper_break, func_and};
                    6'b001100: sel = '{oper_syscall, func_and};
                    default:   hit = 1'b0;
                endcase
            end
            6'b001100: sel = '{oper_aluu, func_and};              // andi
            6'b001101: sel = '{oper_aluu, func_or};               // ori
            6'b001110: sel = '{oper_aluu, func_xor};              // xori
            6'b001111: sel = '{oper_aluu, func_lui};              // lui
            6'b001000: sel = '{oper_alus, func_add};              // addi
            6'b001001: sel = '{oper_aluu, func_add};              // addiu
            6'b001010: sel = '{oper_alus, func_slt};              // slti
            6'b001011: sel = '{oper_aluu, func_slt};              // sltiu
            6'b000010: sel = '{oper_j, func_and};                 // j
            OP_JAL:    sel = '{oper_j, func_and};                 // jal
            6'b000100: sel = '{oper_beq, func_and};
            6'b000101: sel = '{oper_bne, func_and};
            6'b000111: sel = '{oper_bgtz, func_and};
            6'b000110: sel = '{oper_blez, func_and};
            OP_REGIMM: begin
                case (f_rt)
                    5'b00000: sel = '{oper_bltz, func_and};
                    5'b10000: sel = '{oper_bltz, func_and};       // bltzal
                    5'b00001: sel = '{oper_bgez, func_and};
                    5'b10001: sel = '{oper_bgez, func_and};       // bgezal
                    default:  hit = 1'b0;
                endcase
            end
            6'b100000: sel = '{oper_lb, func_add};
            6'b100100: sel = '{oper_lbu, func_add};
            6'b100001: sel = '{oper_lh, func_add};
            6'b100101: sel = '{oper_lhu, func_add};
            6'b100011: sel = '{oper_lw, func_add};
            6'b101000: sel = '{oper_sb, func_add};
            6'b101001: sel = '{oper_sh, func_add};
            6'b101011: sel = '{oper_sw, func_add};
            OP_COP0: begin
                case (f_rs)
                    5'b00100: sel = '{oper_mtc0, func_and};
                    5'b00000: sel = '{oper_mfc0, func_and};
                    5'b10000: sel = '{oper_eret, func_and};
                    default:  hit = 1'b0;
                endcase
            end
            default: hit = 1'b0;
        endcase
    end

    assign is_shift  = sel.func inside {func_sll, func_srl, func_sra};
    assign imm_shift = is_shift & ~inst[2];   // sll srl sra but not the v forms
    assign is_store  = sel.oper inside {oper_sb, oper_sh, oper_sw};
    assign is_jb     = sel.oper inside {oper_jr, oper_j, oper_beq, oper_bne,
                                        oper_bgtz, oper_blez, oper_bltz, oper_bgez};

    always_comb begin
        if (inst[31] | inst[29] | inst[28] | (opcode == OP_REGIMM))
            ityp = ityp_i;
        else if (imm_shift)
            ityp = ityp_i;
        else if (sel.oper inside {oper_j, oper_break, oper_syscall, oper_eret})
            ityp = ityp_j;
        else
            ityp = ityp_r;
    end

    always_comb begin
        imme = '0;
        if (ityp == ityp_i) begin
            if (imm_shift)
                imme = {27'h0, inst[10:6]};               // shamt
            else if (opcode[5:2] == 4'b0011)
                imme = {16'h0, inst[15:0]};               // andi ori xori lui
            else
                imme = {{16{inst[15]}}, inst[15:0]};
        end else if (ityp == ityp_j) begin
            imme = {6'h0, inst[25:0]};
        end
    end

    // shift by shamt reads its source through the rs port
    always_comb begin
        if (ityp == ityp_j || sel.oper inside {oper_mtc0, oper_mfc0})
            rs = '0;
        else if (imm_shift)
            rs = f_rt;
        else
            rs = f_rs;
    end

    always_comb begin
        if (sel.oper inside {oper_beq, oper_bne} || is_shift || is_store)
            rt = f_rt;
        else if (sel.oper == oper_mfc0)
            rt = f_rd;                                    // cp0 register
        else if (ityp == ityp_j || ityp == ityp_i)
            rt = '0;
        else
            rt = f_rt;
    end

    always_comb begin
        if (is_jb || is_store)
            rd_base = '0;
        else if (is_shift)
            rd_base = f_rd;
        else if (ityp == ityp_i || sel.oper == oper_mfc0)
            rd_base = f_rt;
        else if (ityp == ityp_j)
            rd_base = '0;
        else
            rd_base = f_rd;
    end

    assign link_jalr = (opcode == OP_SPECIAL) && (funct == FN_JALR);
    assign link_jal  = (opcode == OP_JAL);
    assign link_bal  = (opcode == OP_REGIMM) && inst[20] && hit;

    always_comb begin
        if (link_jalr)
            rd = (f_rd == '0) ? LINK_REG : f_rd;
        else if (link_jal || link_bal)
            rd = LINK_REG;
        else
            rd = rd_base;
    end

    assign dec = '{
        ityp: ityp,
        oper: sel.oper,
        func: sel.func,
        imme: imme,
        rs:   rs,
        rt:   rt,
        rd:   rd,
        sy:   sel.oper == oper_syscall,
        bp:   sel.oper == oper_break,
        ri:   ~hit,
        er:   sel.oper == oper_eret
    };

endmodule

//--- source/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int       NUM_REGS = 32;
    localparam reg_idx_t LINK_REG = 5'd31;   // ra

    // opcodes and functs that the decoder also checks outside its main match
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_COP0    = 6'b010000;
    localparam logic [5:0] FN_JALR    = 6'b001001;

    typedef enum logic [4:0] {
        oper_alus,
        oper_aluu,
        oper_mfhi,
        oper_mflo,
        oper_mthi,
        oper_mtlo,
        oper_jr,
        oper_j,
        oper_beq,
        oper_bne,
        oper_bgtz,
        oper_blez,
        oper_bltz,
        oper_bgez,
        oper_lb,
        oper_lbu,
        oper_lh,
        oper_lhu,
        oper_lw,
        oper_sb,
        oper_sh,
        oper_sw,
        oper_mtc0,
        oper_mfc0,
        oper_eret,
        oper_break,
        oper_syscall,
        oper_none
    } oper_t;

    typedef enum logic [3:0] {
        func_and,
        func_or,
        func_xor,
        func_nor,
        func_sll,
        func_srl,
        func_sra,
        func_add,
        func_sub,
        func_slt,
        func_mul,
        func_div,
        func_lui
    } func_t;

    typedef enum logic [1:0] {
        ityp_r,
        ityp_i,
        ityp_j
    } ityp_t;

    typedef struct packed {
        ityp_t    ityp;
        oper_t    oper;
        func_t    func;
        word_t    imme;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     sy;   // syscall
        logic     bp;   // break
        logic     ri;   // reserved instruction
        logic     er;   // eret
    } decoded_t;

    typedef struct packed {
        logic     we;
        reg_idx_t addr;
        word_t    data;
    } wb_t;

    typedef struct packed {
        decoded_t dec;
        word_t    op_a;
        word_t    op_b;
    } id_bundle_t;

endpackage
